//--- Makefile
# Verilator build and run of the data-side OBI adapter testbench

TOOL     := verilator
TOP      := tb_obi_data_if
FILELIST := compile.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR  := obj_dir
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+src
src/obi_pkg.sv
src/obi_req_encoder.sv
src/obi_outstanding_tracker.sv
src/obi_resp_checker.sv
src/obi_data_if.sv
testbench/obi_slave_model.sv
testbench/tb_obi_data_if.sv

//--- src/obi_config.svh
////////////////////////////////////////////////////////////
// Bus widths and outstanding-transfer limit of the
// data-side OBI adapter
////////////////////////////////////////////////////////////

`ifndef OBI_CONFIG_SVH
`define OBI_CONFIG_SVH

// Byte address width of the A channel
`define OBI_ADDR_W 32

// Width of wdata and rdata
`define OBI_DATA_W 32

// Queue depth and the highest value of the outstanding counter
`define OBI_MAX_OUTSTANDING 2

`endif

//--- src/obi_data_if.sv
////////////////////////////////////////////////////////////
// Data-side OBI adapter top, encoder, tracker and checker
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_data_if (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               integrity_en_i,
  // Core side
  input  logic               trans_valid_i,
  output logic               trans_ready_o,
  input  obi_pkg::obi_req_t  trans_i,
  output logic               resp_valid_o,
  output obi_pkg::obi_resp_t resp_o,
  output logic               integrity_err_o,
  // OBI side
  output logic               obi_req_o,
  output logic               obi_reqpar_o,
  output obi_pkg::obi_a_t    obi_a_o,
  input  logic               obi_gnt_i,
  input  logic               obi_gntpar_i,
  input  logic               obi_rvalid_i,
  input  logic               obi_rvalidpar_i,
  input  obi_pkg::obi_r_t    obi_r_i
);

  // Head-of-queue attributes for the next response
  logic head_gntpar_err;
  logic head_integrity;
  // Immediate faults from tracker and checker
  logic gntpar_err;
  logic resp_err;
  logic pop;

  // No request buffering, grant is the ready
  assign trans_ready_o   = obi_gnt_i;
  assign integrity_err_o = gntpar_err || resp_err;

  obi_req_encoder u_req_encoder (
    .trans_valid_i (trans_valid_i),
    .trans_i       (trans_i),
    .obi_req_o     (obi_req_o),
    .obi_reqpar_o  (obi_reqpar_o),
    .obi_a_o       (obi_a_o)
  );

  obi_outstanding_tracker u_tracker (
    .clk               (clk),
    .rst_n             (rst_n),
    .obi_req_i         (obi_req_o),
    .obi_gnt_i         (obi_gnt_i),
    .obi_gntpar_i      (obi_gntpar_i),
    .trans_integrity_i (trans_i.integrity),
    .pop_i             (pop),
    .head_gntpar_err_o (head_gntpar_err),
    .head_integrity_o  (head_integrity),
    .gntpar_err_o      (gntpar_err)
  );

  obi_resp_checker u_resp_checker (
    .integrity_en_i    (integrity_en_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_rvalidpar_i   (obi_rvalidpar_i),
    .obi_r_i           (obi_r_i),
    .head_gntpar_err_i (head_gntpar_err),
    .head_integrity_i  (head_integrity),
    .pop_o             (pop),
    .resp_valid_o      (resp_valid_o),
    .resp_o            (resp_o),
    .resp_err_o        (resp_err)
  );

  // A request waiting for its grant keeps its payload
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_a_o));

endmodule

//--- src/obi_outstanding_tracker.sv
////////////////////////////////////////////////////////////
// Outstanding-transfer counter and in-order queue of the
// per-transfer grant-parity error and integrity attribute
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "obi_config.svh"

module obi_outstanding_tracker (
  input  logic clk,
  input  logic rst_n,
  input  logic obi_req_i,
  input  logic obi_gnt_i,
  input  logic obi_gntpar_i,
  input  logic trans_integrity_i,
  input  logic pop_i,
  output logic head_gntpar_err_o,
  output logic head_integrity_o,
  output logic gntpar_err_o
);

  localparam int DEPTH = `OBI_MAX_OUTSTANDING;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // One queued attribute pair per granted transfer
  typedef struct packed {
    logic gntpar_err;
    logic integrity;
  } attr_t;

  attr_t            queue_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             push;
  logic             full;
  logic             empty;

  // Accepted A-channel transfer
  assign push  = obi_req_i && obi_gnt_i;
  assign full  = (cnt_q == CNT_W'(DEPTH));
  assign empty = (cnt_q == '0);

  // Companion equal to the strobe means a parity fault
  assign gntpar_err_o = (obi_gnt_i == obi_gntpar_i);

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    case ({push, pop_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      // Idle, or push and pop together
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Attribute pair captured in the grant cycle
  always_ff @(posedge clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= '{gntpar_err: gntpar_err_o, integrity: trans_integrity_i};
    end
  end

  // Head of queue belongs to the next response
  assign head_gntpar_err_o = queue_q[rd_ptr_q].gntpar_err;
  assign head_integrity_o  = queue_q[rd_ptr_q].integrity;

  // Core must respect the outstanding limit
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push && full |-> pop_i);

  // A response always has a granted transfer behind it
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty);

endmodule

//--- src/obi_pkg.sv
////////////////////////////////////////////////////////////
// Opcode enum and the request, A-channel, R-channel and
// response structs of the data-side OBI adapter
////////////////////////////////////////////////////////////

`include "obi_config.svh"

package obi_pkg;

  // Transfer kind, the value is the OBI we bit
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } obi_op_e;

  // Core-side transaction request
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0]   addr;
    obi_op_e                  op;
    logic [`OBI_DATA_W/8-1:0] be;
    logic [`OBI_DATA_W-1:0]   wdata;
    logic [2:0]               prot;
    logic [1:0]               memtype;
    logic                     dbg;
    // Request asks for rchk checking on its response
    logic                     integrity;
  } obi_req_t;

  // A-channel payload
  // achk[11:8] even parity of wdata bytes 3..0
  // achk[7] parity of the zero atop field, achk[6] odd parity of dbg
  // achk[5] odd parity of {be, we}, achk[4] odd parity of {prot, memtype}
  // achk[3:0] even parity of addr bytes 3..0
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0]   addr;
    obi_op_e                  op;
    logic [`OBI_DATA_W/8-1:0] be;
    logic [`OBI_DATA_W-1:0]   wdata;
    logic [2:0]               prot;
    logic [1:0]               memtype;
    logic                     dbg;
    logic [11:0]              achk;
  } obi_a_t;

  // R-channel payload
  // rchk[4] even parity of err, rchk[3:0] even parity of rdata bytes 3..0
  typedef struct packed {
    logic [`OBI_DATA_W-1:0] rdata;
    logic                   err;
    logic [4:0]             rchk;
  } obi_r_t;

  // Core-side transaction response
  typedef struct packed {
    logic [`OBI_DATA_W-1:0] rdata;
    logic                   err;
    // Echo of the request's integrity attribute
    logic                   integrity;
    // Any parity or checksum fault seen for this transfer
    logic                   integrity_err;
  } obi_resp_t;

endpackage

//--- src/obi_req_encoder.sv
////////////////////////////////////////////////////////////
// Request encoder, maps a transaction request onto the OBI
// A channel and adds achk and reqpar
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "obi_config.svh"

module obi_req_encoder (
  input  logic              trans_valid_i,
  input  obi_pkg::obi_req_t trans_i,
  output logic              obi_req_o,
  output logic              obi_reqpar_o,
  output obi_pkg::obi_a_t   obi_a_o
);

  import obi_pkg::*;

  localparam int ADDR_BYTES = `OBI_ADDR_W / 8;
  localparam int DATA_BYTES = `OBI_DATA_W / 8;

  // OBI write enable derived from the opcode
  logic                  we;
  // Per-byte even parity of wdata and addr
  logic [DATA_BYTES-1:0] wdata_par;
  logic [ADDR_BYTES-1:0] addr_par;

  // Strobe goes straight out, companion is its inverse
  assign obi_req_o    = trans_valid_i;
  assign obi_reqpar_o = ~trans_valid_i;

  assign we = (trans_i.op == OP_WRITE);

  always_comb begin
    for (int i = 0; i < DATA_BYTES; i++) begin
      wdata_par[i] = ^trans_i.wdata[8*i +: 8];
    end
    for (int j = 0; j < ADDR_BYTES; j++) begin
      addr_par[j] = ^trans_i.addr[8*j +: 8];
    end
  end

  ////////////////////////////////////////////////////////////
  // A-channel payload
  ////////////////////////////////////////////////////////////

  always_comb begin
    obi_a_o.addr    = trans_i.addr;
    obi_a_o.op      = trans_i.op;
    obi_a_o.be      = trans_i.be;
    obi_a_o.wdata   = trans_i.wdata;
    obi_a_o.prot    = trans_i.prot;
    obi_a_o.memtype = trans_i.memtype;
    obi_a_o.dbg     = trans_i.dbg;
    // Atop is not driven, its parity bit is that of all zeros
    obi_a_o.achk    = {wdata_par,
                       1'b0,
                       ~trans_i.dbg,
                       ~^{trans_i.be, we},
                       ~^{trans_i.prot, trans_i.memtype},
                       addr_par};
  end

endmodule

//--- src/obi_resp_checker.sv
////////////////////////////////////////////////////////////
// Response checker, rvalid parity and rchk checks merged
// with the queued attributes into the core response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "obi_config.svh"

module obi_resp_checker (
  input  logic               integrity_en_i,
  input  logic               obi_rvalid_i,
  input  logic               obi_rvalidpar_i,
  input  obi_pkg::obi_r_t    obi_r_i,
  input  logic               head_gntpar_err_i,
  input  logic               head_integrity_i,
  output logic               pop_o,
  output logic               resp_valid_o,
  output obi_pkg::obi_resp_t resp_o,
  output logic               resp_err_o
);

  localparam int DATA_BYTES = `OBI_DATA_W / 8;

  // Expected checksum, err parity above the byte parities
  logic [DATA_BYTES:0] rchk_exp;
  logic                rvalidpar_err;
  logic                rchk_err;

  always_comb begin
    for (int i = 0; i < DATA_BYTES; i++) begin
      rchk_exp[i] = ^obi_r_i.rdata[8*i +: 8];
    end
    rchk_exp[DATA_BYTES] = obi_r_i.err;
  end

  // Rvalid parity checked in every cycle, not only with a response
  assign rvalidpar_err = (obi_rvalid_i == obi_rvalidpar_i);

  // Checksum only counts when the transfer asked for it and it is enabled
  assign rchk_err = obi_rvalid_i && head_integrity_i && integrity_en_i &&
                    (obi_r_i.rchk != rchk_exp);

  ////////////////////////////////////////////////////////////
  // Response to the core
  ////////////////////////////////////////////////////////////

  // Consumer is always ready, every rvalid retires one transfer
  assign pop_o        = obi_rvalid_i;
  assign resp_valid_o = obi_rvalid_i;

  always_comb begin
    resp_o.rdata         = obi_r_i.rdata;
    resp_o.err           = obi_r_i.err;
    resp_o.integrity     = head_integrity_i;
    // Grant fault of this transfer joins the response-phase checks
    resp_o.integrity_err = rvalidpar_err || rchk_err || head_gntpar_err_i;
  end

  // Immediate response-phase faults only
  assign resp_err_o = rvalidpar_err || rchk_err;

endmodule

//--- testbench/obi_slave_model.sv
////////////////////////////////////////////////////////////
// In-order OBI responder with a small memory, programmable
// grant delay and parity-error injection
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "obi_config.svh"

module obi_slave_model (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [1:0]      gnt_delay_i,
  input  logic            inj_gntpar_i,
  input  logic            inj_rvalidpar_i,
  input  logic            inj_rchk_i,
  input  logic            req_i,
  input  obi_pkg::obi_a_t a_i,
  output logic            gnt_o,
  output logic            gntpar_o,
  output logic            rvalid_o,
  output logic            rvalidpar_o,
  output obi_pkg::obi_r_t r_o
);

  import obi_pkg::*;

  // One response in flight, with its injected rvalid fault
  typedef struct packed {
    logic   vld;
    logic   bad_par;
    obi_r_t r;
  } rsp_t;

  logic [`OBI_DATA_W-1:0] mem [16];
  logic [1:0]             wait_q;
  rsp_t                   stage_q [2];
  rsp_t                   rsp_d;
  logic [3:0]             idx;

  assign idx      = a_i.addr[5:2];
  assign gnt_o    = req_i && (wait_q >= gnt_delay_i);
  // Companion matches the strobe only on an injected grant
  assign gntpar_o = ~gnt_o ^ (gnt_o & inj_gntpar_i);

  // Response leaves two cycles after its grant
  assign rvalid_o    = stage_q[1].vld;
  assign rvalidpar_o = stage_q[1].bad_par ? rvalid_o : ~rvalid_o;
  assign r_o         = stage_q[1].r;

  always_comb begin
    rsp_d         = '0;
    rsp_d.vld     = gnt_o;
    rsp_d.bad_par = gnt_o && inj_rvalidpar_i;
    if (a_i.op == OP_READ) begin
      rsp_d.r.rdata = mem[idx];
    end
    for (int i = 0; i < 4; i++) begin
      rsp_d.r.rchk[i] = ^rsp_d.r.rdata[8*i +: 8];
    end
    rsp_d.r.rchk[4] = rsp_d.r.err;
    // Corrupted checksum, byte 0 bit flipped
    rsp_d.r.rchk[0] = rsp_d.r.rchk[0] ^ inj_rchk_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q     <= '0;
      stage_q[0] <= '0;
      stage_q[1] <= '0;
    end else begin
      if (!req_i || gnt_o) begin
        wait_q <= '0;
      end else if (wait_q != 2'd3) begin
        wait_q <= wait_q + 1'b1;
      end
      stage_q[0] <= rsp_d;
      stage_q[1] <= stage_q[0];
    end
  end

  // Fill pattern from the word index
  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = {4{4'(i), ~4'(i)}};
    end
  end

  // Byte-enable merge on a granted write
  always @(posedge clk) begin
    if (gnt_o && a_i.op == OP_WRITE) begin
      for (int b = 0; b < 4; b++) begin
        if (a_i.be[b]) begin
          mem[idx][8*b +: 8] <= a_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- testbench/tb_obi_data_if.sv
////////////////////////////////////////////////////////////
// Testbench of the data-side OBI adapter, directed tests,
// scoreboard, watchdog and closing report
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "obi_config.svh"

module tb_obi_data_if;

  import obi_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_XFER     = 50;
  // Worst transfer: 3 wait cycles, 2 response cycles, drive slack
  localparam int XFER_CYCLES = 8;
  localparam int MARGIN      = 200;

  // Expected response of one granted transfer
  typedef struct packed {
    logic                   is_read;
    logic [`OBI_DATA_W-1:0] rdata;
    logic                   integrity;
    logic                   ierr;
    logic                   imm_err;
  } exp_t;

  logic      clk;
  logic      rst_n;
  logic      integrity_en;
  logic      trans_valid;
  logic      trans_ready;
  obi_req_t  trans;
  logic      resp_valid;
  obi_resp_t resp;
  logic      integrity_err;
  logic      obi_req;
  logic      obi_reqpar;
  obi_a_t    obi_a;
  logic      obi_gnt;
  logic      obi_gntpar;
  logic      obi_rvalid;
  logic      obi_rvalidpar;
  obi_r_t    obi_r;
  logic [1:0] gnt_delay;
  logic      inj_gntpar;
  logic      inj_rvalidpar;
  logic      inj_rchk;

  logic [`OBI_DATA_W-1:0] mirror [16];
  exp_t exp_q [$];
  int   seed       = 32'hc2ea;
  int   n_mismatch = 0;
  int   n_other    = 0;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  obi_data_if u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .integrity_en_i  (integrity_en),
    .trans_valid_i   (trans_valid),
    .trans_ready_o   (trans_ready),
    .trans_i         (trans),
    .resp_valid_o    (resp_valid),
    .resp_o          (resp),
    .integrity_err_o (integrity_err),
    .obi_req_o       (obi_req),
    .obi_reqpar_o    (obi_reqpar),
    .obi_a_o         (obi_a),
    .obi_gnt_i       (obi_gnt),
    .obi_gntpar_i    (obi_gntpar),
    .obi_rvalid_i    (obi_rvalid),
    .obi_rvalidpar_i (obi_rvalidpar),
    .obi_r_i         (obi_r)
  );

  obi_slave_model u_slave (
    .clk             (clk),
    .rst_n           (rst_n),
    .gnt_delay_i     (gnt_delay),
    .inj_gntpar_i    (inj_gntpar),
    .inj_rvalidpar_i (inj_rvalidpar),
    .inj_rchk_i      (inj_rchk),
    .req_i           (obi_req),
    .a_i             (obi_a),
    .gnt_o           (obi_gnt),
    .gntpar_o        (obi_gntpar),
    .rvalid_o        (obi_rvalid),
    .rvalidpar_o     (obi_rvalidpar),
    .r_o             (obi_r)
  );

  ////////////////////////////////////////////////////////////
  // Reference checksum and stimulus helpers
  ////////////////////////////////////////////////////////////

  // Even parity bit is the ones count mod 2, odd parity its inverse
  function automatic logic [11:0] calc_achk(input obi_req_t t);
    logic [11:0] c;
    for (int b = 0; b < 4; b++) begin
      c[8+b] = ($countones(t.wdata[8*b +: 8]) % 2) == 1;
      c[b]   = ($countones(t.addr[8*b +: 8]) % 2) == 1;
    end
    c[7] = 1'b0;
    c[6] = !t.dbg;
    c[5] = ($countones({t.be, t.op}) % 2) == 0;
    c[4] = ($countones({t.prot, t.memtype}) % 2) == 0;
    return c;
  endfunction

  // Request fields as the A channel should carry them, checksum zeroed
  function automatic obi_a_t expect_fields(input obi_req_t t);
    obi_a_t a;
    a         = '0;
    a.addr    = t.addr;
    a.op      = t.op;
    a.be      = t.be;
    a.wdata   = t.wdata;
    a.prot    = t.prot;
    a.memtype = t.memtype;
    a.dbg     = t.dbg;
    return a;
  endfunction

  function automatic obi_req_t make_req(input logic [3:0] idx, input obi_op_e op,
                                        input logic [3:0] be, input logic integ);
    obi_req_t t;
    t.addr      = $random(seed);
    t.addr[5:2] = idx;
    t.op        = op;
    t.be        = be;
    t.wdata     = $random(seed);
    t.prot      = 3'($random(seed));
    t.memtype   = 2'($random(seed));
    t.dbg       = 1'($random(seed));
    t.integrity = integ;
    return t;
  endfunction

  // Drive one request and hold it until its grant
  task automatic issue(input obi_req_t t, input logic [1:0] dly, input logic bad_gnt,
                       input logic bad_rvp, input logic bad_rchk);
    @(posedge clk);
    #2;
    trans_valid   = 1'b1;
    trans         = t;
    gnt_delay     = dly;
    inj_gntpar    = bad_gnt;
    inj_rvalidpar = bad_rvp;
    inj_rchk      = bad_rchk;
    @(negedge clk);
    while (!trans_ready) @(negedge clk);
  endtask

  // Bus goes idle, then every outstanding response must come back
  task automatic finish_seq();
    @(posedge clk);
    #2;
    trans_valid   = 1'b0;
    inj_gntpar    = 1'b0;
    inj_rvalidpar = 1'b0;
    inj_rchk      = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic check_resp(input exp_t e);
    if (e.is_read) begin
      assert (resp.rdata == e.rdata) else begin
        n_mismatch++;
        $display("MISMATCH resp_o.rdata: got %h expected %h", resp.rdata, e.rdata);
      end
    end
    // Slave model never answers with a bus error
    assert (resp.err == 1'b0) else begin
      n_mismatch++;
      $display("MISMATCH resp_o.err: got %h expected %h", resp.err, 1'b0);
    end
    assert (resp.integrity == e.integrity) else begin
      n_mismatch++;
      $display("MISMATCH resp_o.integrity: got %h expected %h", resp.integrity, e.integrity);
    end
    assert (resp.integrity_err == e.ierr) else begin
      n_mismatch++;
      $display("MISMATCH resp_o.integrity_err: got %h expected %h",
               resp.integrity_err, e.ierr);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    exp_t   e_new;
    exp_t   e_got;
    obi_a_t got_a;
    logic   exp_ierr;
    if (rst_n) begin
      exp_ierr = 1'b0;
      // Strobes and companions pass straight through
      assert (obi_req == trans_valid) else begin
        n_mismatch++;
        $display("MISMATCH obi_req_o: got %h expected %h", obi_req, trans_valid);
      end
      assert (obi_reqpar == !trans_valid) else begin
        n_mismatch++;
        $display("MISMATCH obi_reqpar_o: got %h expected %h", obi_reqpar, !trans_valid);
      end
      assert (trans_ready == obi_gnt) else begin
        n_mismatch++;
        $display("MISMATCH trans_ready_o: got %h expected %h", trans_ready, obi_gnt);
      end
      if (obi_req) begin
        assert (obi_a.achk == calc_achk(trans)) else begin
          n_mismatch++;
          $display("MISMATCH obi_a_o.achk: got %h expected %h", obi_a.achk, calc_achk(trans));
        end
        got_a      = obi_a;
        got_a.achk = '0;
        assert (got_a == expect_fields(trans)) else begin
          n_mismatch++;
          $display("MISMATCH obi_a_o: got %h expected %h", got_a, expect_fields(trans));
        end
      end
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          n_other++;
          $display("Response arrived with no transfer outstanding");
        end else begin
          e_got    = exp_q.pop_front();
          exp_ierr = e_got.imm_err;
          check_resp(e_got);
        end
      end
      // Granted transfer, expected response from the memory copy
      if (obi_req && obi_gnt) begin
        exp_ierr        = exp_ierr || inj_gntpar;
        e_new.is_read   = (trans.op == OP_READ);
        e_new.rdata     = mirror[trans.addr[5:2]];
        e_new.integrity = trans.integrity;
        e_new.imm_err   = inj_rvalidpar || (inj_rchk && trans.integrity && integrity_en);
        e_new.ierr      = inj_gntpar || e_new.imm_err;
        if (trans.op == OP_WRITE) begin
          for (int b = 0; b < 4; b++) begin
            if (trans.be[b]) begin
              mirror[trans.addr[5:2]][8*b +: 8] = trans.wdata[8*b +: 8];
            end
          end
        end
        exp_q.push_back(e_new);
      end
      // Grant and response-phase faults both show in their own cycle
      assert (integrity_err == exp_ierr) else begin
        n_mismatch++;
        $display("MISMATCH integrity_err_o: got %h expected %h", integrity_err, exp_ierr);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  // Fill every word, then partial writes read back
  task automatic test_write_read();
    logic [3:0] idx;
    for (int i = 0; i < 16; i++) begin
      issue(make_req(4'(i), OP_WRITE, 4'hf, 1'b0), 2'd0, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      idx = 4'($random(seed));
      issue(make_req(idx, OP_WRITE, 4'($random(seed)), 1'b1), 2'(i), 1'b0, 1'b0, 1'b0);
      issue(make_req(idx, OP_READ, 4'hf, 1'b0), 2'(i + 1), 1'b0, 1'b0, 1'b0);
    end
    finish_seq();
  endtask

  // Random grant delays keep two transfers in flight
  task automatic test_pipelined();
    obi_op_e op;
    for (int i = 0; i < 8; i++) begin
      op = obi_op_e'($random(seed));
      issue(make_req(4'($random(seed)), op, 4'($random(seed)), 1'($random(seed))),
            2'($random(seed)), 1'b0, 1'b0, 1'b0);
    end
    finish_seq();
  endtask

  // Only the middle transfer carries the grant fault
  task automatic test_gnt_parity();
    issue(make_req(4'd1, OP_READ, 4'hf, 1'b0), 2'd1, 1'b0, 1'b0, 1'b0);
    issue(make_req(4'd2, OP_READ, 4'hf, 1'b1), 2'd1, 1'b1, 1'b0, 1'b0);
    issue(make_req(4'd3, OP_READ, 4'hf, 1'b0), 2'd0, 1'b0, 1'b0, 1'b0);
    finish_seq();
  endtask

  // rchk fault counts only with the flag set and checking enabled
  task automatic test_resp_errors();
    integrity_en = 1'b1;
    issue(make_req(4'd4, OP_READ, 4'hf, 1'b1), 2'd0, 1'b0, 1'b1, 1'b0);
    issue(make_req(4'd5, OP_READ, 4'hf, 1'b1), 2'd0, 1'b0, 1'b0, 1'b1);
    issue(make_req(4'd6, OP_READ, 4'hf, 1'b0), 2'd2, 1'b0, 1'b0, 1'b1);
    finish_seq();
    integrity_en = 1'b0;
    issue(make_req(4'd7, OP_READ, 4'hf, 1'b1), 2'd0, 1'b0, 1'b0, 1'b1);
    finish_seq();
    integrity_en = 1'b1;
  endtask

  initial begin
    rst_n         = 1'b0;
    integrity_en  = 1'b1;
    trans_valid   = 1'b0;
    trans         = '0;
    gnt_delay     = 2'd0;
    inj_gntpar    = 1'b0;
    inj_rvalidpar = 1'b0;
    inj_rchk      = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_write_read();
    test_pipelined();
    test_gnt_parity();
    test_resp_errors();
    $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the transfer count
  initial begin
    #((N_XFER * XFER_CYCLES + 16 + MARGIN) * CLK_PERIOD);
    $display("Timeout, the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule
